/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen     = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0]             word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
  typedef logic [6:0]                  opcode_t;
  typedef logic [2:0]                  funct3_t;

  // Major opcodes kept by this core
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_jal     = 7'b1101111;
  localparam opcode_t op_store   = 7'b0100011;
  localparam opcode_t op_system  = 7'b1110011;

  localparam logic [6:0] funct7_alt = 7'b0100000; // SUB and SRA/SRAI

  // ALU class funct3
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101; // SRL or SRA, split by funct7
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // Branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam funct3_t f3_sw   = 3'b010; // Only word stores

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_imm,  // LUI upper immediate
    wb_link  // JAL return address
  } wb_sel_t;

  localparam word_t insn_step = 32'd4;
  localparam word_t nop_insn  = 32'h00000013; // ADDI x0,x0,0

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1,
  output rv_pkg::word_t     rs1_data,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  // x0 has no storage behind it
  word_t regs [1:num_regs-1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/insn_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module insn_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::funct3_t   funct3,
  output rv_pkg::word_t     imm_i,
  output rv_pkg::word_t     imm_s,
  output rv_pkg::word_t     imm_b,
  output rv_pkg::word_t     imm_j,
  output rv_pkg::word_t     imm_u,
  output rv_pkg::alu_op_t   alu_op,
  output logic              use_imm,
  output rv_pkg::wb_sel_t   wb_sel,
  output logic              reg_we,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_store,
  output logic              is_halt
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;
  logic       alt;

  // Shared by the register-immediate and register-register classes
  function automatic alu_op_t f3_to_op(funct3_t f3, logic sub_sra);
    alu_op_t op;
    case (f3)
      f3_add:  op = sub_sra ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = sub_sra ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign alt    = (funct7 == funct7_alt);

  // Sign-extended immediates, insn[31] is always the sign
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    alu_op    = alu_add;
    use_imm   = 1'b0;
    wb_sel    = wb_alu;
    reg_we    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_store  = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      op_lui: begin
        wb_sel = wb_imm;
        reg_we = 1'b1;
      end
      op_reg_imm: begin
        // ADDI has no SUB form, only the shift takes funct7
        alu_op  = f3_to_op(funct3, alt && (funct3 == f3_sr));
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      op_reg_reg: begin
        alu_op = f3_to_op(funct3, alt);
        reg_we = 1'b1;
      end
      op_branch: is_branch = 1'b1;
      op_jal: begin
        is_jal = 1'b1;
        wb_sel = wb_link;
        reg_we = 1'b1;
      end
      op_store:  is_store = (funct3 == f3_sw);
      op_system: is_halt  = (insn[31:7] == '0); // ECALL
      default: ; // Unknown opcodes do nothing
    endcase
  end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt); // Sign bit fills from the left
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::funct3_t funct3,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            halt,
  input  rv_pkg::word_t   imm_b,
  input  rv_pkg::word_t   imm_j,
  output rv_pkg::word_t   next_pc,
  output rv_pkg::word_t   link
);
  import rv_pkg::*;

  logic cond;
  logic taken;

  always_comb begin
    case (funct3)
      f3_beq:  cond = (rs1_data == rs2_data);
      f3_bne:  cond = (rs1_data != rs2_data);
      f3_blt:  cond = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  cond = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: cond = rs1_data < rs2_data;
      f3_bgeu: cond = rs1_data >= rs2_data;
      default: cond = 1'b0; // Reserved encodings fall through
    endcase
  end

  assign taken = is_branch && cond;
  assign link  = pc + insn_step;

  // Halt wins, so the ECALL repeats forever
  always_comb begin
    if (halt) begin
      next_pc = pc;
    end else if (is_jal) begin
      next_pc = pc + imm_j;
    end else if (taken) begin
      next_pc = pc + imm_b;
    end else begin
      next_pc = link;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t store_addr,
  output rv_pkg::word_t store_data,
  output logic          store_we,
  output logic          halt
);
  import rv_pkg::*;

  word_t     exec_insn;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  funct3_t   funct3;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_j;
  word_t     imm_u;
  alu_op_t   alu_op;
  logic      use_imm;
  wb_sel_t   wb_sel;
  logic      reg_we;
  logic      is_branch;
  logic      is_jal;
  logic      is_store;
  logic      is_halt;
  logic      rf_we;
  word_t     rd_data;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     alu_result;
  word_t     next_pc;
  word_t     link;

  // A NOP is executed while in reset
  assign exec_insn = rst ? nop_insn : insn;

  insn_decode decode_i (
    .insn      (exec_insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm_i     (imm_i),
    .imm_s     (imm_s),
    .imm_b     (imm_b),
    .imm_j     (imm_j),
    .imm_u     (imm_u),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .wb_sel    (wb_sel),
    .reg_we    (reg_we),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_store  (is_store),
    .is_halt   (is_halt)
  );

  assign rf_we    = reg_we && !rst;
  assign store_we = is_store && !rst;
  assign halt     = is_halt && !rst;

  reg_file regs_i (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1      (rs1),
    .rs1_data (rs1_data),
    .rs2      (rs2),
    .rs2_data (rs2_data)
  );

  assign alu_b = use_imm ? imm_i : rs2_data;

  alu alu_i (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  branch_unit branch_i (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .funct3    (funct3),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .halt      (halt),
    .imm_b     (imm_b),
    .imm_j     (imm_j),
    .next_pc   (next_pc),
    .link      (link)
  );

  always_comb begin
    case (wb_sel)
      wb_imm:  rd_data = imm_u;
      wb_link: rd_data = link;
      default: rd_data = alu_result;
    endcase
  end

  // SW address and data straight from the register file
  assign store_addr = rs1_data + imm_s;
  assign store_data = rs2_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* verification/rv_program.svh */
`ifndef rv_program_svh
`define rv_program_svh

// Program image indexed by pc/4, and the stores it must produce in order
word_t prog [0:511];
word_t exp_addr [0:127];
word_t exp_data [0:127];
int    n_prog;
int    n_exp;
word_t next_addr;
word_t lcg_state;
word_t ecall_pc;

function automatic word_t lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return {lcg_state[15:0], lcg_state[31:16]}; // Better bits go low
endfunction

function automatic word_t i_type(word_t imm, reg_addr_t rs1, funct3_t f3, reg_addr_t rd);
  return {imm[11:0], rs1, f3, rd, op_reg_imm};
endfunction

function automatic word_t s_type(word_t imm, reg_addr_t rs2);
  return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store}; // SW with x0 base
endfunction

task automatic emit(word_t w);
  prog[n_prog] = w;
  n_prog++;
endtask

// LUI plus ADDI, upper part rounded for the sign-extended low part
task automatic load_reg(reg_addr_t rd, word_t value);
  word_t upper;
  upper = value + 32'h800;
  emit({upper[31:12], rd, op_lui});
  emit(i_type(value, rd, 3'b000, rd));
endtask

task automatic store_reg(reg_addr_t rs2, word_t data);
  emit(s_type(next_addr, rs2));
  exp_addr[n_exp] = next_addr;
  exp_data[n_exp] = data;
  n_exp++;
  next_addr += 4;
endtask

task automatic build_program();
  word_t   a;
  word_t   b;
  word_t   imm;
  funct3_t f3;
  logic    alt;
  n_prog    = 0;
  n_exp     = 0;
  next_addr = 32'h100;
  lcg_state = 32'd18691;
  // ALU section, first pass with rs1 negative and rs2 positive
  for (int rep = 0; rep < 2; rep++) begin
    for (int k = 0; k < 10; k++) begin
      a   = lcg_next() | {rep == 0, 31'd0};
      b   = lcg_next() & {rep != 0, 31'h7fffffff};
      imm = lcg_next();
      f3  = (k == 9) ? 3'd0 : (k == 8) ? 3'd5 : funct3_t'(k);
      alt = (k >= 8); // SRA, then SUB
      load_reg(5'd1, a);
      load_reg(5'd3, b);
      emit({alt ? funct7_alt : 7'd0, 5'd3, 5'd1, f3, 5'd2, op_reg_reg});
      store_reg(5'd2, expected_result(f3, alt, a, b));
      if (k == 9) begin
        emit({imm[31:12], 5'd2, op_lui});
        store_reg(5'd2, {imm[31:12], 12'd0});
      end else begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {21'd0, alt, 5'd0, imm[4:0]}; // Shift amount with funct7
        end else begin
          imm = {{20{imm[11]}}, imm[11:0]};
        end
        emit(i_type(imm, 5'd1, f3, 5'd2));
        store_reg(5'd2, expected_result(f3, alt, a, imm));
      end
    end
  end
  // x0 ignores both writes
  emit({20'habcde, 5'd0, op_lui});
  emit(i_type(32'h123, 5'd0, 3'b000, 5'd0));
  store_reg(5'd0, 32'd0);
  // Branches by +8 skip one store when taken
  for (int rep = 0; rep < 2; rep++) begin
    for (int k = 0; k < 8; k++) begin
      if (k == 2 || k == 3) continue;
      a = lcg_next() | {rep != 0, 31'd0};
      b = (rep == 0) ? a : (lcg_next() & 32'h7fffffff);
      load_reg(5'd1, a);
      load_reg(5'd3, b);
      emit({1'b0, 6'd0, 5'd3, 5'd1, funct3_t'(k), 4'd4, 1'b0, op_branch});
      if (branch_taken(funct3_t'(k), a, b)) begin
        emit(s_type(32'h7fc, 5'd1));
      end else begin
        store_reg(5'd1, a);
      end
    end
  end
  a = word_t'(n_prog * 4) + 32'd4; // Link of the JAL
  emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd5, op_jal});
  emit(s_type(32'h7fc, 5'd5));
  store_reg(5'd5, a);
  ecall_pc = word_t'(n_prog * 4);
  emit(32'h00000073);
  emit(s_type(32'h7fc, 5'd0)); // Never reached
endtask

`endif

/* verification/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int half_period  = 50;
  localparam int drive_delay  = 1;
  localparam int settle_delay = 2 * half_period - 11; // Sample 10 ns before the edge
  localparam int max_cycles   = 1000;
  localparam int hold_cycles  = 6;

  logic  clk;
  logic  rst;
  word_t insn;
  word_t pc;
  word_t store_addr;
  word_t store_data;
  logic  store_we;
  logic  halt;
  int    n_seen;
  int    cycle;

  // Reference results from the RV32I definitions
  function automatic word_t expected_result(funct3_t f3, logic alt, word_t a, word_t b);
    logic lt;
    lt = (a[31] != b[31]) ? a[31] : (a < b); // Signed less-than
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, lt};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffffffff >> b[4:0]) : 32'd0);
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
    logic lt;
    lt = (a[31] != b[31]) ? a[31] : (a < b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return lt;
      3'd5: return !lt;
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  `include "rv_program.svh"

  rv_core dut_i (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_we   (store_we),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  task automatic stop_with_failure(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare_value(string name, word_t actual, word_t expected);
    assert (actual == expected)
      else stop_with_failure($sformatf("** Error: %s = %h, expected %h",
                                       name, actual, expected));
  endtask

  function automatic word_t fetch_insn(word_t addr);
    return (addr < word_t'(n_prog * 4)) ? prog[addr[10:2]] : nop_insn;
  endfunction

  task automatic advance();
    @(posedge clk);
    #drive_delay;
    insn = fetch_insn(pc);
    #settle_delay;
  endtask

  task automatic check_store();
    if (store_we) begin
      assert (n_seen < n_exp)
        else stop_with_failure("A store appeared that the program does not expect");
      assert (store_addr == exp_addr[n_seen])
        else stop_with_failure($sformatf("** Error: store_addr = %h, expected %h",
                                         store_addr, exp_addr[n_seen]));
      assert (store_data == exp_data[n_seen])
        else stop_with_failure($sformatf("** Error: store_data = %h, expected %h",
                                         store_data, exp_data[n_seen]));
      n_seen++;
    end
  endtask

  task automatic check_halt_hold();
    assert (n_seen == n_exp)
      else stop_with_failure($sformatf("Halt came after %0d of %0d expected stores",
                                       n_seen, n_exp));
    assert (pc == ecall_pc)
      else stop_with_failure($sformatf("** Error: pc = %h, expected %h", pc, ecall_pc));
    repeat (hold_cycles) begin
      advance();
      compare_value("halt", word_t'(halt), 32'd1);
      compare_value("store_we", word_t'(store_we), '0);
      compare_value("pc", pc, ecall_pc);
    end
  endtask

  initial begin
    rst    = 1'b1;
    insn   = nop_insn;
    n_seen = 0;
    build_program();
    repeat (8) begin
      @(posedge clk);
      #drive_delay;
      compare_value("pc", pc, '0);
      compare_value("store_we", word_t'(store_we), '0);
      compare_value("halt", word_t'(halt), '0);
    end
    rst  = 1'b0;
    insn = fetch_insn(pc);
    #settle_delay;
    // Straight-line code at the start steps pc by 4
    cycle = 0;
    while (!halt && cycle < max_cycles) begin
      if (cycle < 4) begin
        assert (pc == word_t'(cycle * 4))
          else stop_with_failure($sformatf("** Error: pc = %h, expected %h", pc, cycle * 4));
      end
      check_store();
      advance();
      cycle++;
    end
    if (!halt) begin
      stop_with_failure("Timeout: halt never rose within the cycle limit");
    end else begin
      check_halt_hold();
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/insn_decode.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/rv_core.sv
verification/tb_rv_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rv_core
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
